/* src/snn_pkg.sv */
package snn_pkg;

	// router link, one flit per router_clk write
	localparam int flit_w = 4;
	localparam int packet_w = 32;
	// the least significant flit of a packet comes first
	localparam int flits_per_packet = 8;

	// tile coordinates and axon indexing
	localparam int coord_w = 8;
	localparam int num_axons = 16;
	localparam int axon_id_w = 4;

	// neuron arithmetic, all values are two's complement
	localparam int weight_w = 8;
	localparam int potential_w = 16;
	// wide enough for the potential plus sixteen weights plus the leak
	localparam int acc_w = 20;

	// packet buffer between the two clock domains
	localparam int fifo_depth = 4;
	localparam int fifo_addr_w = 2;

	// configuration port
	localparam int cfg_addr_w = 5;
	localparam int cfg_data_w = 16;

	// address map, weights occupy num_axons consecutive words from the base
	localparam logic [cfg_addr_w-1:0] cfg_weight_base = cfg_addr_w'(0);
	localparam logic [cfg_addr_w-1:0] cfg_threshold = cfg_addr_w'(16);
	localparam logic [cfg_addr_w-1:0] cfg_leak = cfg_addr_w'(17);
	// low byte is x, high byte is y
	localparam logic [cfg_addr_w-1:0] cfg_tile_addr = cfg_addr_w'(18);

	typedef logic signed [acc_w-1:0] acc_t;

	// saturation limits of the membrane potential, held at accumulator width
	localparam acc_t pot_max = acc_t'(2 ** (potential_w - 1) - 1);
	localparam acc_t pot_min = acc_t'(-(2 ** (potential_w - 1)));

	// spike packet, dest_x sits in the first flits on the wire
	typedef struct packed {
		logic [packet_w-axon_id_w-2*coord_w-1:0] reserved;
		logic [axon_id_w-1:0] axon_id;
		logic [coord_w-1:0] dest_y;
		logic [coord_w-1:0] dest_x;
	} spike_packet_t;

	typedef struct packed {
		logic [coord_w-1:0] y;
		logic [coord_w-1:0] x;
	} tile_addr_t;

	typedef struct packed {
		logic we;
		logic [cfg_addr_w-1:0] addr;
		logic [cfg_data_w-1:0] data;
	} cfg_wr_t;

	// weights are signed, the core reinterprets each slice
	typedef struct packed {
		logic [num_axons-1:0][weight_w-1:0] weights;
		logic [potential_w-1:0] threshold;
		logic [potential_w-1:0] leak;
	} neuron_params_t;

endpackage

/* src/flit_async_fifo.sv */
module flit_async_fifo (
	input logic router_clk,
	input logic neuron_clk,
	input logic rst_n,
	input logic flit_we,
	input logic [snn_pkg::flit_w-1:0] flit_data,
	input logic pkt_rd,
	output snn_pkg::spike_packet_t packet,
	output logic pkt_empty,
	output logic neuron_full
);

	// pointers carry one extra bit to tell a full buffer from an empty one
	logic [snn_pkg::fifo_addr_w:0] wr_bin;
	logic [snn_pkg::fifo_addr_w:0] wr_bin_nxt;
	logic [snn_pkg::fifo_addr_w:0] wr_gray;
	logic [snn_pkg::fifo_addr_w:0] wr_gray_nxt;
	logic [snn_pkg::fifo_addr_w:0] rd_bin;
	logic [snn_pkg::fifo_addr_w:0] rd_bin_nxt;
	logic [snn_pkg::fifo_addr_w:0] rd_gray;
	logic [snn_pkg::fifo_addr_w:0] rd_gray_nxt;

	// two-flop synchronisers, one for each direction
	logic [snn_pkg::fifo_addr_w:0] rd_gray_s1;
	logic [snn_pkg::fifo_addr_w:0] rd_gray_s2;
	logic [snn_pkg::fifo_addr_w:0] wr_gray_s1;
	logic [snn_pkg::fifo_addr_w:0] wr_gray_s2;

	// packet assembly holds the first seven flits, the eighth goes straight to memory
	logic [$clog2(snn_pkg::flits_per_packet)-1:0] flit_cnt;
	logic [snn_pkg::packet_w-snn_pkg::flit_w-1:0] asm_q;
	logic flit_ok;
	logic last_flit;
	logic wr_full;
	logic rd_en;

	snn_pkg::spike_packet_t mem [snn_pkg::fifo_depth];

	// router side

	// a write under full is dropped here, the router is expected not to try
	assign flit_ok = flit_we && !neuron_full;
	assign last_flit = flit_cnt == $bits(flit_cnt)'(snn_pkg::flits_per_packet - 1);

	assign wr_bin_nxt = wr_bin + 1'b1;
	assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

	// full when the write pointer has lapped the read pointer,
	// which in Gray code means the two top bits differ and the rest match
	assign wr_full = wr_gray == {~rd_gray_s2[snn_pkg::fifo_addr_w -: 2],
		rd_gray_s2[snn_pkg::fifo_addr_w-2:0]};

	// full is only raised between packets, so a packet that was started always has
	// a free slot waiting and its last flit cannot be refused
	assign neuron_full = wr_full && (flit_cnt == '0);

	always_ff @(posedge router_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			flit_cnt <= '0;
			wr_bin <= '0;
			wr_gray <= '0;
		end
		else if (flit_ok)
		begin
			if (last_flit)
			begin
				flit_cnt <= '0;
				wr_bin <= wr_bin_nxt;
				wr_gray <= wr_gray_nxt;
			end
			else
			begin
				flit_cnt <= flit_cnt + 1'b1;
			end
		end
	end

	// each new flit enters at the top, so the first one ends up at bit 0
	always_ff @(posedge router_clk)
	begin
		if (flit_ok)
		begin
			asm_q <= {flit_data, asm_q[snn_pkg::packet_w-snn_pkg::flit_w-1:snn_pkg::flit_w]};
			if (last_flit)
				mem[wr_bin[snn_pkg::fifo_addr_w-1:0]] <= snn_pkg::spike_packet_t'({flit_data, asm_q});
		end
	end

	// read pointer brought over into the router domain
	always_ff @(posedge router_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end
		else
		begin
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	// neuron side

	assign pkt_empty = rd_gray == wr_gray_s2;
	assign rd_en = pkt_rd && !pkt_empty;

	assign rd_bin_nxt = rd_bin + 1'b1;
	assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
			rd_bin <= '0;
			rd_gray <= '0;
		end
		else
		begin
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			if (rd_en)
			begin
				rd_bin <= rd_bin_nxt;
				rd_gray <= rd_gray_nxt;
			end
		end
	end

	// the packet shows up one neuron_clk cycle after the read request
	always_ff @(posedge neuron_clk)
	begin
		if (rd_en)
			packet <= mem[rd_bin[snn_pkg::fifo_addr_w-1:0]];
	end

	// the router must hold off while the tile reports full
	a_no_write_when_full: assert property (@(posedge router_clk) disable iff (!rst_n)
		!(flit_we && neuron_full));

endmodule

/* src/spike_decoder.sv */
module spike_decoder (
	input logic neuron_clk,
	input logic rst_n,
	input snn_pkg::spike_packet_t packet,
	input logic pkt_empty,
	output logic pkt_rd,
	input snn_pkg::tile_addr_t tile_addr,
	input logic start,
	output logic [snn_pkg::num_axons-1:0] axon_spikes
);

	// write strobe lines up with the packet coming back from the FIFO
	logic wr_strobe;
	// delayed start that wipes the spike vector for the next time step
	logic clear_q;
	logic hit;

	// drain one packet per cycle as fast as the FIFO offers them
	assign pkt_rd = ~pkt_empty;

	// only packets aimed at this tile count and the reserved bits play no part
	assign hit = (packet.dest_x == tile_addr.x) && (packet.dest_y == tile_addr.y);

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_strobe <= 1'b0;
			clear_q <= 1'b0;
		end
		else
		begin
			wr_strobe <= pkt_rd;
			clear_q <= start;
		end
	end

	// the clear wins over a spike landing in the same cycle
	// repeated packets for one axon simply set the same bit again
	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			axon_spikes <= '0;
		end
		else if (clear_q)
		begin
			axon_spikes <= '0;
		end
		else if (wr_strobe && hit)
		begin
			axon_spikes[packet.axon_id] <= 1'b1;
		end
	end

	// a new packet from the FIFO appears only together with the strobe
	// and otherwise the packet register holds still
	a_packet_moves_with_strobe: assert property (@(posedge neuron_clk) disable iff (!rst_n)
		!wr_strobe |-> $stable(packet));

endmodule

/* src/neuron_config.sv */
module neuron_config (
	input logic neuron_clk,
	input logic rst_n,
	input snn_pkg::cfg_wr_t cfg,
	output snn_pkg::tile_addr_t tile_addr,
	output snn_pkg::neuron_params_t params
);

	// offset of the address into the weight window
	logic [snn_pkg::cfg_addr_w-1:0] weight_off;
	logic weight_hit;

	assign weight_off = cfg.addr - snn_pkg::cfg_weight_base;
	assign weight_hit = weight_off < snn_pkg::num_axons;

	// one write per cycle, unmapped addresses fall through the case unnoticed
	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			params <= '0;
			tile_addr <= '0;
		end
		else if (cfg.we)
		begin
			if (weight_hit)
			begin
				// weights use the low byte only, as a signed value
				params.weights[weight_off[snn_pkg::axon_id_w-1:0]] <=
					cfg.data[snn_pkg::weight_w-1:0];
			end
			else
			begin
				case (cfg.addr)
					snn_pkg::cfg_threshold:
					begin
						params.threshold <= cfg.data;
					end
					snn_pkg::cfg_leak:
					begin
						params.leak <= cfg.data;
					end
					snn_pkg::cfg_tile_addr:
					begin
						// x in the low byte, y in the high byte, same as the struct
						tile_addr <= snn_pkg::tile_addr_t'(cfg.data);
					end
					default:
					begin
					end
				endcase
			end
		end
	end

endmodule

/* src/neuron_core.sv */
module neuron_core (
	input logic neuron_clk,
	input logic rst_n,
	input logic start,
	input logic [snn_pkg::num_axons-1:0] axon_spikes,
	input snn_pkg::neuron_params_t params,
	output logic fire,
	output logic signed [snn_pkg::potential_w-1:0] potential
);

	// full precision sum before clipping
	snn_pkg::acc_t acc;
	// potential after saturation to the 16-bit range
	logic signed [snn_pkg::potential_w-1:0] sat;
	logic reached;

	// integrate every spiking axon and leak once per step
	always_comb
	begin
		acc = snn_pkg::acc_t'(potential);
		for (int i = 0; i < snn_pkg::num_axons; i++)
		begin
			if (axon_spikes[i])
				acc = acc + snn_pkg::acc_t'($signed(params.weights[i]));
		end
		acc = acc - snn_pkg::acc_t'($signed(params.leak));
	end

	// clip instead of wrapping so that strong inhibition pins the membrane at the floor
	always_comb
	begin
		if (acc > snn_pkg::pot_max)
			sat = snn_pkg::pot_max[snn_pkg::potential_w-1:0];
		else if (acc < snn_pkg::pot_min)
			sat = snn_pkg::pot_min[snn_pkg::potential_w-1:0];
		else
			sat = acc[snn_pkg::potential_w-1:0];
	end

	assign reached = sat >= $signed(params.threshold);

	// the membrane only moves on a start pulse and holds between steps
	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fire <= 1'b0;
			potential <= '0;
		end
		else
		begin
			// fire lasts a single cycle since start is a single-cycle pulse
			fire <= start && reached;
			if (start)
			begin
				if (reached)
					potential <= '0;
				else
					potential <= sat;
			end
		end
	end

	// fire is a one-cycle pulse as long as start never lasts two cycles
	a_fire_single_cycle: assert property (@(posedge neuron_clk) disable iff (!rst_n)
		fire |=> !fire);

endmodule

/* src/neuron_tile.sv */
module neuron_tile (
	input logic router_clk,
	input logic neuron_clk,
	input logic rst_n,
	input logic flit_we,
	input logic [snn_pkg::flit_w-1:0] flit_data,
	output logic neuron_full,
	input snn_pkg::cfg_wr_t cfg,
	input logic start,
	output logic [snn_pkg::num_axons-1:0] spike,
	output logic fire,
	output logic signed [snn_pkg::potential_w-1:0] potential
);

	// packet path between the FIFO and the decoder
	snn_pkg::spike_packet_t packet;
	logic pkt_empty;
	logic pkt_rd;

	// settings from the register block
	snn_pkg::tile_addr_t tile_addr;
	snn_pkg::neuron_params_t params;

	// flits in on router_clk, whole packets out on neuron_clk
	flit_async_fifo flit_async_fifo_inst (
		.router_clk (router_clk),
		.neuron_clk (neuron_clk),
		.rst_n (rst_n),
		.flit_we (flit_we),
		.flit_data (flit_data),
		.pkt_rd (pkt_rd),
		.packet (packet),
		.pkt_empty (pkt_empty),
		.neuron_full (neuron_full)
	);

	// the spike vector is also the tile's spike output
	spike_decoder spike_decoder_inst (
		.neuron_clk (neuron_clk),
		.rst_n (rst_n),
		.packet (packet),
		.pkt_empty (pkt_empty),
		.pkt_rd (pkt_rd),
		.tile_addr (tile_addr),
		.start (start),
		.axon_spikes (spike)
	);

	neuron_config neuron_config_inst (
		.neuron_clk (neuron_clk),
		.rst_n (rst_n),
		.cfg (cfg),
		.tile_addr (tile_addr),
		.params (params)
	);

	// core samples the spike vector in the start cycle, before the decoder clears it
	neuron_core neuron_core_inst (
		.neuron_clk (neuron_clk),
		.rst_n (rst_n),
		.start (start),
		.axon_spikes (spike),
		.params (params),
		.fire (fire),
		.potential (potential)
	);

endmodule

/* sim/tb_neuron_tile.sv */
module tb_neuron_tile;

	timeunit 1ns;
	timeprecision 1ps;

	logic router_clk;
	logic neuron_clk;
	logic rst_n;
	logic flit_we;
	logic [snn_pkg::flit_w-1:0] flit_data;
	logic neuron_full;
	snn_pkg::cfg_wr_t cfg;
	logic start;
	logic [snn_pkg::num_axons-1:0] spike;
	logic fire;
	logic signed [snn_pkg::potential_w-1:0] potential;

	// commands parsed from the tests file with one entry per command line
	byte cmd_q [$];
	int arg_a [$];
	int arg_b [$];
	int arg_c [$];

	// reference model of the tile
	int weights [snn_pkg::num_axons];
	int threshold;
	int leak;
	int tile_x;
	int tile_y;
	int model_pot;
	logic [snn_pkg::num_axons-1:0] model_mask;

	logic [31:0] lfsr;
	int cycles;
	int cycle_limit;

	neuron_tile neuron_tile_inst (
		.router_clk (router_clk),
		.neuron_clk (neuron_clk),
		.rst_n (rst_n),
		.flit_we (flit_we),
		.flit_data (flit_data),
		.neuron_full (neuron_full),
		.cfg (cfg),
		.start (start),
		.spike (spike),
		.fire (fire),
		.potential (potential)
	);

	always #5 neuron_clk = ~neuron_clk;
	// router runs slower and unrelated to the neuron clock
	always #7 router_clk = ~router_clk;

	// Fibonacci form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// reinterpret the low bits of a value as two's complement
	function automatic int sign_extend(input int value, input int bits);
		int v;
		v = value & ((1 << bits) - 1);
		if (v >= (1 << (bits - 1)))
			v = v - (1 << bits);
		return v;
	endfunction

	task automatic report_error(input string msg);
		$display("FAIL at %0d ns: %s", $time, msg);
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	// the whole file is parsed up front so the timeout can scale with it
	task automatic load_tests();
		int fd;
		int n;
		byte cmd;
		int a;
		int b;
		int c;
		string line;
		fd = $fopen("sim/neuron_tile_tests.txt", "r");
		if (fd == 0)
		begin
			abort_run("could not open the tests file sim/neuron_tile_tests.txt");
		end
		else
		begin
			while ($fscanf(fd, " %c", cmd) == 1)
			begin
				n = $fgets(line, fd);
				a = 0;
				b = 0;
				c = 0;
				// lines starting with a hash are comments
				if (cmd != "#")
				begin
					if (cmd == "W")
						n = $sscanf(line, "%h", a);
					else
						n = $sscanf(line, "%d %d %d", a, b, c);
					cmd_q.push_back(cmd);
					arg_a.push_back(a);
					arg_b.push_back(b);
					arg_c.push_back(c);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic write_config(input int addr, input int data);
		@(negedge neuron_clk);
		cfg.we = 1'b1;
		cfg.addr = snn_pkg::cfg_addr_w'(addr);
		cfg.data = snn_pkg::cfg_data_w'(data);
		@(negedge neuron_clk);
		cfg.we = 1'b0;
		// mirror the register map since the tile ignores any other address
		if (addr < snn_pkg::num_axons)
			weights[addr] = sign_extend(data, snn_pkg::weight_w);
		else if (addr == int'(snn_pkg::cfg_threshold))
			threshold = sign_extend(data, snn_pkg::potential_w);
		else if (addr == int'(snn_pkg::cfg_leak))
			leak = sign_extend(data, snn_pkg::potential_w);
		else if (addr == int'(snn_pkg::cfg_tile_addr))
		begin
			tile_x = data & 8'hff;
			tile_y = (data >> 8) & 8'hff;
		end
	endtask

	// flits go out back to back with the lowest nibble first and pause only while full
	task automatic send_packet(input int x, input int y, input int axon);
		snn_pkg::spike_packet_t pkt;
		pkt.dest_x = snn_pkg::coord_w'(x);
		pkt.dest_y = snn_pkg::coord_w'(y);
		pkt.axon_id = snn_pkg::axon_id_w'(axon);
		// reserved bits are noise the decoder has to ignore
		for (int i = 0; i < $bits(pkt.reserved); i++)
		begin
			lfsr = lfsr_step(lfsr);
			pkt.reserved[i] = lfsr[0];
		end
		for (int i = 0; i < snn_pkg::flits_per_packet; i++)
		begin
			@(negedge router_clk);
			while (neuron_full)
			begin
				flit_we = 1'b0;
				@(negedge router_clk);
			end
			flit_we = 1'b1;
			flit_data = pkt[i*snn_pkg::flit_w +: snn_pkg::flit_w];
		end
		if (x == tile_x && y == tile_y)
			model_mask[axon] = 1'b1;
	endtask

	// ends a run of flit writes once the last one has been clocked in
	task automatic release_router();
		if (flit_we)
		begin
			@(negedge router_clk);
			flit_we = 1'b0;
		end
	endtask

	task automatic check_spikes(input int mask);
		repeat (8) @(negedge neuron_clk);
		if (mask != int'(model_mask))
			abort_run($sformatf("tests file mask %h disagrees with the model mask %h",
				mask, model_mask));
		else
			assert (spike == model_mask)
			else report_error($sformatf("spike is %h, expected %h", spike, model_mask));
	endtask

	// the model integrates first and then the DUT gets its start pulse
	task automatic run_step(input int file_fire, input int file_pot);
		int sum;
		logic exp_fire;
		sum = model_pot - leak;
		for (int i = 0; i < snn_pkg::num_axons; i++)
		begin
			if (model_mask[i])
				sum = sum + weights[i];
		end
		if (sum > (1 << (snn_pkg::potential_w - 1)) - 1)
			sum = (1 << (snn_pkg::potential_w - 1)) - 1;
		else if (sum < -(1 << (snn_pkg::potential_w - 1)))
			sum = -(1 << (snn_pkg::potential_w - 1));
		exp_fire = sum >= threshold;
		model_pot = exp_fire ? 0 : sum;
		model_mask = '0;
		if (file_fire != int'(exp_fire) || file_pot != model_pot)
			abort_run($sformatf("tests file expects fire %0d potential %0d, model gives %0d %0d",
				file_fire, file_pot, exp_fire, model_pot));
		else
		begin
			@(negedge neuron_clk);
			start = 1'b1;
			@(negedge neuron_clk);
			start = 1'b0;
			assert (fire == exp_fire && int'(potential) == model_pot)
			else report_error($sformatf("fire %0d potential %0d, expected %0d %0d",
				fire, potential, exp_fire, model_pot));
			// a cycle later fire has dropped and the spike register is empty
			@(negedge neuron_clk);
			assert (!fire && spike == '0)
			else report_error($sformatf("after the step fire %0d spike %h", fire, spike));
		end
	endtask

	always @(posedge neuron_clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			abort_run($sformatf("simulation timed out after %0d neuron_clk cycles", cycles));
	end

	initial
	begin
		neuron_clk = 1'b0;
		router_clk = 1'b0;
		rst_n = 1'b0;
		flit_we = 1'b0;
		flit_data = '0;
		cfg = '0;
		start = 1'b0;
		lfsr = 32'h72560e8a;
		cycles = 0;
		cycle_limit = 0;
		threshold = 0;
		leak = 0;
		tile_x = 0;
		tile_y = 0;
		model_pot = 0;
		model_mask = '0;
		foreach (weights[i])
			weights[i] = 0;
		load_tests();
		cycle_limit = 200 * cmd_q.size();
		repeat (10) @(negedge neuron_clk);
		assert (!neuron_full && !fire && spike == '0 && potential == '0)
		else report_error("outputs are not zero during reset");
		rst_n = 1'b1;
		foreach (cmd_q[k])
		begin
			// packets in a row stay back to back on the router link
			if (cmd_q[k] != "P")
				release_router();
			case (cmd_q[k])
				"C": write_config(arg_a[k], arg_b[k]);
				"P": send_packet(arg_a[k], arg_b[k], arg_c[k]);
				"W": check_spikes(arg_a[k]);
				"S": run_step(arg_a[k], arg_b[k]);
				default: abort_run($sformatf("unknown command %c in the tests file", cmd_q[k]));
			endcase
		end
		release_router();
		$display("test passed");
		$finish;
	end

endmodule

/* sim/neuron_tile_tests.txt */
# C addr data (decimal) | P x y axon | W spike mask (hex) | S fire potential (decimal)
# the first write places the tile at x 3 y 5, 1283 is 0x0503
C 18 1283
C 0 20
C 1 35
C 2 -7
C 3 62
C 4 10
C 16 100
C 17 5
C 20 999
# axon 1 twice, wrong x and wrong y dropped
P 3 5 0
P 3 5 1
P 3 5 1
P 4 5 2
P 3 6 3
W 0003
S 0 50
# lands exactly on the threshold
P 3 5 3
P 3 5 2
W 000c
S 1 0
# burst of six packets, one with a wrong x
P 3 5 4
P 3 5 5
P 3 5 6
P 3 5 7
P 2 5 8
P 3 5 9
W 02f0
S 0 5
# strong inhibition pins the potential at the floor
C 10 -128
C 11 -128
C 12 -128
C 17 32767
P 3 5 10
P 3 5 11
P 3 5 12
W 1c00
S 0 -32768
S 0 -32768

/* flist.f */
src/snn_pkg.sv
src/flit_async_fifo.sv
src/spike_decoder.sv
src/neuron_config.sv
src/neuron_core.sv
src/neuron_tile.sv
sim/tb_neuron_tile.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_neuron_tile \
	-f flist.f -o tb_neuron_tile > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_neuron_tile > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
